/* include/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Instruction and data width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

`endif

/* logic/decodePkg.sv */
package decodePkg;

    // Opcode class, picked from instr[6:0]
    typedef enum logic [2:0] {
        rType  = 3'd0,
        iType  = 3'd1,
        load   = 3'd2,
        store  = 3'd3,
        branch = 3'd4,
        other  = 3'd5
    } opClassE;

    // ALU operation hint handed to execute
    typedef enum logic [1:0] {
        addOp   = 2'b00, // Address add for load/store
        subCmp  = 2'b01, // Compare for branch
        functOp = 2'b10  // Decode by funct3/funct7
    } aluOpE;

    // Load/store flag
    typedef enum logic [1:0] {
        noAccess    = 2'b00,
        storeAccess = 2'b01,
        loadAccess  = 2'b10
    } memAccessE;

    // Control bundle, 10 bits
    typedef struct packed {
        logic      regWrite;
        logic      aluSrc;    // Immediate as second operand
        logic      branch;
        logic      memRead;
        logic      memWrite;
        logic      memToReg;
        aluOpE     aluOp;
        memAccessE memAccess;
    } ctrlS;

endpackage

/* logic/uopIf.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

interface uopIf;
    logic                   valid;
    logic                   ready;
    decodePkg::opClassE     opClass;
    decodePkg::ctrlS        ctrl;
    logic                   illegal;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic [6:0]             funct7;

    modport producer (
        output valid, opClass, ctrl, illegal, imm, rs1, rs2, rd, funct3, funct7,
        input  ready
    );

    modport consumer (
        input  valid, opClass, ctrl, illegal, imm, rs1, rs2, rd, funct3, funct7,
        output ready
    );
endinterface

/* logic/controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder (
    input  logic [6:0]         opcode,
    output decodePkg::opClassE opClass,
    output decodePkg::ctrlS    ctrl,
    output logic               illegal
);
    // RV32I major opcodes for the supported classes
    typedef enum logic [6:0] {
        opcRType  = 7'b0110011,
        opcIType  = 7'b0010011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcBranch = 7'b1100011
    } opcodeE;

    always_comb begin
        case (opcode)
            opcRType:  opClass = decodePkg::rType;
            opcIType:  opClass = decodePkg::iType;
            opcLoad:   opClass = decodePkg::load;
            opcStore:  opClass = decodePkg::store;
            opcBranch: opClass = decodePkg::branch;
            default:   opClass = decodePkg::other;
        endcase
    end

    // Controls follow from the class alone
    always_comb begin
        ctrl           = '0;
        ctrl.aluOp     = decodePkg::addOp;
        ctrl.memAccess = decodePkg::noAccess;
        illegal        = 1'b0;
        case (opClass)
            decodePkg::rType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = decodePkg::functOp;
            end
            decodePkg::iType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodePkg::functOp;
            end
            decodePkg::load: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.memAccess = decodePkg::loadAccess;
            end
            decodePkg::store: begin
                ctrl.aluSrc    = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.memAccess = decodePkg::storeAccess;
            end
            decodePkg::branch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = decodePkg::subCmp;
            end
            default: illegal = 1'b1; // Unsupported opcode
        endcase
    end

endmodule

/* logic/immGenerator.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module immGenerator (
    input  logic [`XLEN-1:0]   instr,
    input  decodePkg::opClassE opClass,
    output logic [`XLEN-1:0]   imm
);
    logic [11:0] immField; // Raw 12-bit field before extension

    always_comb begin
        case (opClass)
            decodePkg::iType,
            decodePkg::load: begin
                immField = instr[31:20];
            end
            decodePkg::store: begin
                immField = {instr[31:25], instr[11:7]};
            end
            decodePkg::branch: begin
                // Branch offset bits 12,11,10:5,4:1 packed into 12 bits
                immField = {instr[31], instr[7], instr[30:25], instr[11:8]};
            end
            default: begin
                immField = '0; // R-type and illegal carry no immediate
            end
        endcase
    end

    // Field MSB is instr[31] for every layout
    assign imm = {{(`XLEN-12){immField[11]}}, immField};

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module decodeStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             instrValid,
    output logic             instrReady,
    input  logic [`XLEN-1:0] instr,
    uopIf.producer           uop
);
    decodePkg::opClassE decOpClass;
    decodePkg::ctrlS    decCtrl;
    logic               decIllegal;
    logic [`XLEN-1:0]   decImm;
    logic               accept;

    controlDecoder ctrlDec (
        .opcode  (instr[6:0]),
        .opClass (decOpClass),
        .ctrl    (decCtrl),
        .illegal (decIllegal)
    );

    immGenerator immGen (
        .instr   (instr),
        .opClass (decOpClass),
        .imm     (decImm)
    );

    // Empty, or draining this cycle
    assign instrReady = !uop.valid || uop.ready;
    assign accept     = instrValid && instrReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            uop.valid <= 1'b0;
        end else if (instrReady) begin
            uop.valid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop.opClass <= decOpClass;
            uop.ctrl    <= decCtrl;
            uop.illegal <= decIllegal;
            uop.imm     <= decImm;
            uop.rs1     <= instr[19:15];
            uop.rs2     <= instr[24:20];
            uop.rd      <= instr[11:7];
            uop.funct3  <= instr[14:12];
            uop.funct7  <= instr[31:25];
        end
    end

    // A stalled micro-op must hold until operandRead takes it
    assert property (@(posedge clk) disable iff (!rstN)
        uop.valid && !uop.ready |=> uop.valid &&
            $stable({uop.opClass, uop.ctrl, uop.illegal, uop.imm, uop.rs1,
                     uop.rs2, uop.rd, uop.funct3, uop.funct7}))
        else $error("uop changed while stalled");

endmodule

/* logic/operandRead.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module operandRead (
    input  logic                   clk,
    input  logic                   rstN,
    uopIf.consumer                 uop,
    input  logic                   wbEn,
    input  logic [`REG_ADDR_W-1:0] wbAddr,
    input  logic [`XLEN-1:0]       wbData,
    output logic                   outValid,
    input  logic                   outReady,
    output decodePkg::opClassE     outClass,
    output decodePkg::ctrlS        outCtrl,
    output logic                   outIllegal,
    output logic [`REG_ADDR_W-1:0] outRd,
    output logic [2:0]             outFunct3,
    output logic [6:0]             outFunct7,
    output logic [`XLEN-1:0]       outImm,
    output logic [`XLEN-1:0]       outRs1Data,
    output logic [`XLEN-1:0]       outRs2Data
);
    logic [`XLEN-1:0] regFile [`NUM_REGS];
    logic             accept;

    // Register file, x0 never written so it stays zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbEn && wbAddr != '0) begin
            regFile[wbAddr] <= wbData;
        end
    end

    assign uop.ready = !outValid || outReady;
    assign accept    = uop.valid && uop.ready;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (uop.ready) begin
            outValid <= uop.valid;
        end
    end

    // Operands sampled together with the micro-op
    always_ff @(posedge clk) begin
        if (accept) begin
            outClass   <= uop.opClass;
            outCtrl    <= uop.ctrl;
            outIllegal <= uop.illegal;
            outRd      <= uop.rd;
            outFunct3  <= uop.funct3;
            outFunct7  <= uop.funct7;
            outImm     <= uop.imm;
            outRs1Data <= regFile[uop.rs1];
            outRs2Data <= regFile[uop.rs2];
        end
    end

    // Source x0 must come out as zero
    assert property (@(posedge clk) disable iff (!rstN)
        accept && uop.rs1 == '0 |=> outValid && outRs1Data == '0)
        else $error("rs1 of x0 read nonzero");

    assert property (@(posedge clk) disable iff (!rstN)
        accept && uop.rs2 == '0 |=> outValid && outRs2Data == '0)
        else $error("rs2 of x0 read nonzero");

endmodule

/* logic/decodeTop.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module decodeTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,
    output logic                    instrReady,
    input  logic [`XLEN-1:0]        instr,
    input  logic                    wbEn,
    input  logic [`REG_ADDR_W-1:0]  wbAddr,
    input  logic [`XLEN-1:0]        wbData,
    output logic                    outValid,
    input  logic                    outReady,
    output decodePkg::opClassE      outClass,
    output logic                    outRegWrite,
    output logic                    outAluSrc,
    output logic                    outBranch,
    output logic                    outMemRead,
    output logic                    outMemWrite,
    output logic                    outMemToReg,
    output decodePkg::aluOpE        outAluOp,
    output decodePkg::memAccessE    outMemAccess,
    output logic [`REG_ADDR_W-1:0]  outRd,
    output logic [2:0]              outFunct3,
    output logic [6:0]              outFunct7,
    output logic [`XLEN-1:0]        outImm,
    output logic [`XLEN-1:0]        outRs1Data,
    output logic [`XLEN-1:0]        outRs2Data,
    output logic                    outIllegal
);
    decodePkg::ctrlS ctrlOut;

    uopIf uopBus ();

    decodeStage decStage (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .uop        (uopBus.producer)
    );

    operandRead opRead (
        .clk        (clk),
        .rstN       (rstN),
        .uop        (uopBus.consumer),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .outValid   (outValid),
        .outReady   (outReady),
        .outClass   (outClass),
        .outCtrl    (ctrlOut),
        .outIllegal (outIllegal),
        .outRd      (outRd),
        .outFunct3  (outFunct3),
        .outFunct7  (outFunct7),
        .outImm     (outImm),
        .outRs1Data (outRs1Data),
        .outRs2Data (outRs2Data)
    );

    // Control bundle split onto flat ports
    assign outRegWrite  = ctrlOut.regWrite;
    assign outAluSrc    = ctrlOut.aluSrc;
    assign outBranch    = ctrlOut.branch;
    assign outMemRead   = ctrlOut.memRead;
    assign outMemWrite  = ctrlOut.memWrite;
    assign outMemToReg  = ctrlOut.memToReg;
    assign outAluOp     = ctrlOut.aluOp;
    assign outMemAccess = ctrlOut.memAccess;

endmodule

/* tb/decodeChecker.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module decodeChecker (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  logic                   instrReady,
    input  logic [`XLEN-1:0]       instr,
    input  logic                   outValid,
    input  logic                   outReady,
    input  decodePkg::opClassE     outClass,
    input  logic [9:0]             outCtrl,    // Flat control ports in ctrlS order
    input  logic                   outIllegal,
    input  logic [`REG_ADDR_W-1:0] outRd,
    input  logic [2:0]             outFunct3,
    input  logic [6:0]             outFunct7,
    input  logic [`XLEN-1:0]       outImm,
    input  logic [`XLEN-1:0]       outRs1Data,
    input  logic [`XLEN-1:0]       outRs2Data,
    output int                     mismatchCount,
    output int                     otherCount,
    output int                     pendingCount
);
    typedef struct packed {
        logic [2:0]             opClass;
        logic [9:0]             ctrl;
        logic                   illegal;
        logic [`REG_ADDR_W-1:0] rd;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       rs1Data;
        logic [`XLEN-1:0]       rs2Data;
    } expS;

    expS  expQ[$];
    int   acceptQ[$]; // Cycle of acceptance
    int   snapQ[$];   // Stall count seen at acceptance
    int   cycle;
    int   lowCount;   // Edges with outReady low so far
    logic resetSeen;

    // Expected micro-op from the class, control and immediate rules
    function automatic expS refDecode(input logic [`XLEN-1:0] word);
        expS         e;
        logic [11:0] field;
        e         = '0;
        field     = '0;
        e.rd      = word[11:7];
        e.funct3  = word[14:12];
        e.funct7  = word[31:25];
        e.rs1Data = decodeTb.shadowRegs[word[19:15]];
        e.rs2Data = decodeTb.shadowRegs[word[24:20]];
        // Flag order: regWrite aluSrc branch memRead memWrite memToReg
        case (word[6:0])
            7'b0110011: begin
                e.opClass = decodePkg::rType;
                e.ctrl    = {6'b100000, decodePkg::functOp, decodePkg::noAccess};
            end
            7'b0010011: begin
                e.opClass = decodePkg::iType;
                e.ctrl    = {6'b110000, decodePkg::functOp, decodePkg::noAccess};
                field     = word[31:20];
            end
            7'b0000011: begin
                e.opClass = decodePkg::load;
                e.ctrl    = {6'b110101, decodePkg::addOp, decodePkg::loadAccess};
                field     = word[31:20];
            end
            7'b0100011: begin
                e.opClass = decodePkg::store;
                e.ctrl    = {6'b010010, decodePkg::addOp, decodePkg::storeAccess};
                field     = {word[31:25], word[11:7]};
            end
            7'b1100011: begin
                e.opClass = decodePkg::branch;
                e.ctrl    = {6'b001000, decodePkg::subCmp, decodePkg::noAccess};
                field     = {word[31], word[7], word[30:25], word[11:8]};
            end
            default: begin
                e.opClass = decodePkg::other;
                e.ctrl    = {6'b000000, decodePkg::addOp, decodePkg::noAccess};
                e.illegal = 1'b1;
            end
        endcase
        e.imm = {{(`XLEN-12){field[11]}}, field};
        return e;
    endfunction

    task automatic checkField(input string name, input logic [`XLEN-1:0] expVal,
                              input logic [`XLEN-1:0] actVal);
        if (actVal !== expVal) begin
            mismatchCount++;
            $display("Mismatch %s: expected %h, actual %h", name, expVal, actVal);
        end
    endtask

    task automatic compareOutputs(input expS want);
        checkField("outClass", want.opClass, outClass);
        checkField("outRegWrite", want.ctrl[9], outCtrl[9]);
        checkField("outAluSrc", want.ctrl[8], outCtrl[8]);
        checkField("outBranch", want.ctrl[7], outCtrl[7]);
        checkField("outMemRead", want.ctrl[6], outCtrl[6]);
        checkField("outMemWrite", want.ctrl[5], outCtrl[5]);
        checkField("outMemToReg", want.ctrl[4], outCtrl[4]);
        checkField("outAluOp", want.ctrl[3:2], outCtrl[3:2]);
        checkField("outMemAccess", want.ctrl[1:0], outCtrl[1:0]);
        checkField("outIllegal", want.illegal, outIllegal);
        checkField("outRd", want.rd, outRd);
        checkField("outFunct3", want.funct3, outFunct3);
        checkField("outFunct7", want.funct7, outFunct7);
        checkField("outImm", want.imm, outImm);
        checkField("outRs1Data", want.rs1Data, outRs1Data);
        checkField("outRs2Data", want.rs2Data, outRs2Data);
    endtask

    initial begin
        resetSeen = 1'b0;
    end

    always @(posedge clk) begin
        expS want;
        int  acceptedAt;
        int  lowSnap;
        if (rstN) begin
            cycle++;
            if (!resetSeen) begin
                resetSeen = 1'b1;
                if (outValid !== 1'b0) begin
                    otherCount++;
                    $display("outValid was not low after reset");
                end
                if (instrReady !== 1'b1) begin
                    otherCount++;
                    $display("instrReady did not rise within one cycle of reset release");
                end
            end
            // Output side taking data leaves room for a new instruction
            if (outReady && instrReady !== 1'b1) begin
                otherCount++;
                $display("instrReady was low while outReady was high");
            end
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    otherCount++;
                    $display("Output transfer with no accepted instruction behind it");
                end else begin
                    want       = expQ.pop_front();
                    acceptedAt = acceptQ.pop_front();
                    lowSnap    = snapQ.pop_front();
                    compareOutputs(want);
                    // No stall since acceptance means the bare 2-cycle path
                    if (lowSnap == lowCount && cycle - acceptedAt != 2) begin
                        otherCount++;
                        $display("Output came %0d cycles after acceptance instead of 2",
                                 cycle - acceptedAt);
                    end
                end
            end
            if (!outReady) begin
                lowCount++;
            end
            if (instrValid && instrReady) begin
                expQ.push_back(refDecode(instr));
                acceptQ.push_back(cycle);
                snapQ.push_back(lowCount);
            end
            pendingCount = expQ.size();
        end
    end

endmodule

/* tb/decodeTb.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module decodeTb;
    localparam int NUM_INSTR = 300;
    localparam int BURST_LEN = 16;
    // 300 instructions at about 4 cycles each, plus preload, burst and margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    logic                   instrReady;
    logic [`XLEN-1:0]       instr;
    logic                   wbEn;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;
    logic                   outValid;
    logic                   outReady;
    decodePkg::opClassE     outClass;
    logic                   outRegWrite;
    logic                   outAluSrc;
    logic                   outBranch;
    logic                   outMemRead;
    logic                   outMemWrite;
    logic                   outMemToReg;
    decodePkg::aluOpE       outAluOp;
    decodePkg::memAccessE   outMemAccess;
    logic [`REG_ADDR_W-1:0] outRd;
    logic [2:0]             outFunct3;
    logic [6:0]             outFunct7;
    logic [`XLEN-1:0]       outImm;
    logic [`XLEN-1:0]       outRs1Data;
    logic [`XLEN-1:0]       outRs2Data;
    logic                   outIllegal;

    logic [`XLEN-1:0] shadowRegs [`NUM_REGS]; // Mirror of the preloaded register file
    logic             randomBackPressure;
    int               cycleCount;
    int               mismatchCount;
    int               otherCount;
    int               pendingCount;

    decodeTop uut (.*);

    decodeChecker chk (
        .*,
        .outCtrl ({outRegWrite, outAluSrc, outBranch, outMemRead, outMemWrite,
                   outMemToReg, outAluOp, outMemAccess})
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Moves to the next falling edge and drives outReady there
    task automatic stepCycle();
        @(negedge clk);
        outReady = randomBackPressure ? ($urandom % 3 != 0) : 1'b1;
    endtask

    task automatic sendInstr(input logic [`XLEN-1:0] word);
        instrValid = 1'b1;
        instr      = word;
        @(posedge clk);
        while (!instrReady) begin
            stepCycle();
            @(posedge clk);
        end
        stepCycle();
    endtask

    task automatic preloadRegs();
        logic [`XLEN-1:0] value;
        for (int r = 0; r < `NUM_REGS; r++) begin
            value         = $urandom;
            wbEn          = 1'b1;
            wbAddr        = r[`REG_ADDR_W-1:0];
            wbData        = value;
            shadowRegs[r] = (r == 0) ? '0 : value; // x0 write gets dropped
            stepCycle();
        end
        wbEn = 1'b0;
    endtask

    function automatic logic [`XLEN-1:0] makeInstr();
        logic [`XLEN-1:0] word;
        word = $urandom;
        case ($urandom % 6)
            0:       word[6:0] = 7'b0110011;
            1:       word[6:0] = 7'b0010011;
            2:       word[6:0] = 7'b0000011;
            3:       word[6:0] = 7'b0100011;
            4:       word[6:0] = 7'b1100011;
            default: word[2]   = 1'b1; // Bit 2 set lies outside all five classes
        endcase
        if ($urandom % 8 == 0) begin
            word[19:15] = '0; // Source x0
        end
        if ($urandom % 8 == 0) begin
            word[24:20] = '0;
        end
        return word;
    endfunction

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Mismatches: %0d, other errors: %0d", mismatchCount, otherCount + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        void'($urandom(44));
        rstN               = 1'b0;
        instrValid         = 1'b0;
        instr              = '0;
        wbEn               = 1'b0;
        wbAddr             = '0;
        wbData             = '0;
        outReady           = 1'b0;
        randomBackPressure = 1'b0;
        repeat (2) @(posedge clk);
        stepCycle();
        rstN = 1'b1;
        preloadRegs();
        // Back-to-back burst with outReady held high
        for (int n = 0; n < BURST_LEN; n++) begin
            sendInstr(makeInstr());
        end
        instrValid         = 1'b0;
        randomBackPressure = 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            if ($urandom % 4 == 0) begin
                instrValid = 1'b0;
                repeat (1 + $urandom % 2) stepCycle();
            end
            sendInstr(makeInstr());
        end
        instrValid         = 1'b0;
        randomBackPressure = 1'b0;
        while (pendingCount != 0) begin
            stepCycle();
        end
        repeat (4) stepCycle(); // Room for any stray extra output
        $display("Mismatches: %0d, other errors: %0d", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
logic/decodePkg.sv
logic/uopIf.sv
logic/controlDecoder.sv
logic/immGenerator.sv
logic/decodeStage.sv
logic/operandRead.sv
logic/decodeTop.sv
tb/decodeChecker.sv
tb/decodeTb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - include
    files:
      - logic/decodePkg.sv
      - logic/uopIf.sv
      - logic/controlDecoder.sv
      - logic/immGenerator.sv
      - logic/decodeStage.sv
      - logic/operandRead.sv
      - logic/decodeTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/decodeChecker.sv
      - tb/decodeTb.sv
